// ==== design/cdp_rdma_pkg.sv ====
package cdp_rdma_pkg;

  // ==============================
  // widths and sizes
  // ==============================
  // memory address width
  localparam int MEM_ADDR_BW = 40;
  // 32 byte atoms
  localparam int ATOM_SHIFT = 5;
  // atoms per width group
  localparam int W_GROUP_ATOMS = 8;
  localparam int W_GROUP_SHIFT = $clog2(W_GROUP_ATOMS);
  // byte step between width groups
  localparam int GROUP_BYTES = W_GROUP_ATOMS << ATOM_SHIFT;
  // cube registers hold value minus one
  localparam int CUBE_DIM_W = 13;
  localparam int STRIDE_W = 32;
  // channel group counter
  localparam int CH_GRP_W = CUBE_DIM_W - ATOM_SHIFT;
  // width group counter, up to 1024 groups
  localparam int W_GRP_W = CUBE_DIM_W + 1 - W_GROUP_SHIFT;

  // dma request payload, address low and size above
  localparam int DMA_SIZE_W = 15;
  localparam int DMA_REQ_PD_W = MEM_ADDR_BW + DMA_SIZE_W;
  // context queue entry: size, last w, last h, last c
  localparam int CQ_PD_W = 6;

  localparam int REQ_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(REQ_FIFO_DEPTH);
  // perf counter width
  localparam int PERF_W = 32;

  // ==============================
  // types
  // ==============================
  typedef logic [MEM_ADDR_BW-1:0] addr_t;
  // size in atoms minus one
  typedef logic [W_GROUP_SHIFT-1:0] size_t;
  typedef logic [CUBE_DIM_W-1:0] cube_dim_t;
  typedef logic [STRIDE_W-1:0] stride_t;

  // one pending request, 46 bits
  typedef struct packed {
    addr_t addr;
    size_t size;
    logic  last_w;
    logic  last_h;
    logic  last_c;
  } req_entry_t;

  typedef enum logic [1:0] {
    WALK_IDLE,
    WALK_RUN,
    WALK_WAIT_DONE
  } walker_state_e;

endpackage

// ==== design/cdp_rdma_cube_walker.sv ====
`timescale 1ns/1ns

module cdp_rdma_cube_walker (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     op_en,
  input  logic                     eg_done,
  input  cdp_rdma_pkg::cube_dim_t  channel,
  input  cdp_rdma_pkg::cube_dim_t  height,
  input  cdp_rdma_pkg::cube_dim_t  width,
  input  cdp_rdma_pkg::addr_t      src_base_addr,
  input  cdp_rdma_pkg::stride_t    src_line_stride,
  input  cdp_rdma_pkg::stride_t    src_surface_stride,
  input  logic                     full,
  output logic                     push,
  output cdp_rdma_pkg::req_entry_t entry
);
  import cdp_rdma_pkg::*;

  walker_state_e state;
  logic [CH_GRP_W-1:0] ch_grp_cnt;
  logic [W_GRP_W-1:0] w_grp_cnt;
  cube_dim_t line_cnt;
  addr_t line_base;
  addr_t wgrp_base;
  addr_t cur_addr;
  logic [CUBE_DIM_W:0] width_use;
  logic [W_GRP_W-1:0] w_grp_num;
  logic load;
  logic is_first_w;
  logic is_last_w;
  logic is_last_h;
  logic is_last_c;
  logic is_cube_end;
  size_t req_size;
  addr_t next_line_addr;
  addr_t next_wgrp_addr;

  // ==============================
  // layer control
  // ==============================
  // start a walk only from idle
  assign load = (state == WALK_IDLE) & op_en;
  // one entry per cycle while running and fifo has room
  assign push = (state == WALK_RUN) & ~full;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      state <= WALK_IDLE;
    end else begin
      case (state)
        WALK_IDLE: if (op_en) state <= WALK_RUN;
        WALK_RUN: if (push && is_cube_end) state <= WALK_WAIT_DONE;
        // hold until egress has drained the layer
        WALK_WAIT_DONE: if (eg_done) state <= WALK_IDLE;
        default: state <= WALK_IDLE;
      endcase
    end
  end

  // ==============================
  // cube position
  // ==============================
  // groups of 8 in width, rounded up
  assign width_use = {1'b0, width} + 1'b1;
  assign w_grp_num = width_use[CUBE_DIM_W:W_GROUP_SHIFT] +
                     W_GRP_W'(|width_use[W_GROUP_SHIFT-1:0]);

  assign is_first_w = (w_grp_cnt == '0);
  assign is_last_w = (w_grp_cnt == w_grp_num - 1'b1);
  assign is_last_h = (line_cnt == height);
  assign is_last_c = (ch_grp_cnt == channel[CUBE_DIM_W-1:ATOM_SHIFT]);
  assign is_cube_end = is_last_w & is_last_h & is_last_c;

  // channel innermost, then width group, then line
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      ch_grp_cnt <= '0;
      w_grp_cnt <= '0;
      line_cnt <= '0;
    end else if (load) begin
      ch_grp_cnt <= '0;
      w_grp_cnt <= '0;
      line_cnt <= '0;
    end else if (push) begin
      ch_grp_cnt <= is_last_c ? '0 : ch_grp_cnt + 1'b1;
      if (is_last_c) begin
        w_grp_cnt <= is_last_w ? '0 : w_grp_cnt + 1'b1;
      end
      if (is_last_c && is_last_w) begin
        line_cnt <= is_last_h ? '0 : line_cnt + 1'b1;
      end
    end
  end

  // ==============================
  // address stepping
  // ==============================
  assign next_line_addr = line_base + addr_t'(src_line_stride);
  assign next_wgrp_addr = wgrp_base + addr_t'(GROUP_BYTES);

  always_ff @(posedge nvdla_core_clk) begin
    if (load) begin
      line_base <= src_base_addr;
      wgrp_base <= src_base_addr;
      cur_addr <= src_base_addr;
    end else if (push) begin
      if (is_last_c && is_last_w) begin
        // new line restarts at width group 0
        line_base <= next_line_addr;
        wgrp_base <= next_line_addr;
        cur_addr <= next_line_addr;
      end else if (is_last_c) begin
        wgrp_base <= next_wgrp_addr;
        cur_addr <= next_wgrp_addr;
      end else begin
        // next channel group, one surface on
        cur_addr <= cur_addr + addr_t'(src_surface_stride);
      end
    end
  end

  // ==============================
  // request size
  // ==============================
  // a lone group is also the last, so first wins
  always_comb begin
    if (is_first_w) begin
      req_size = (w_grp_num == 1) ? width[W_GROUP_SHIFT-1:0] : size_t'(W_GROUP_ATOMS - 1);
    end else if (is_last_w) begin
      req_size = width[W_GROUP_SHIFT-1:0];
    end else begin
      req_size = size_t'(W_GROUP_ATOMS - 1);
    end
  end

  assign entry = '{
    addr: cur_addr,
    size: req_size,
    last_w: is_last_w,
    last_h: is_last_h,
    last_c: is_last_c
  };

endmodule

// ==== design/cdp_rdma_req_fifo.sv ====
`timescale 1ns/1ns

module cdp_rdma_req_fifo (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     push,
  input  logic                     pop,
  input  cdp_rdma_pkg::req_entry_t wr_entry,
  output logic                     full,
  output logic                     empty,
  output cdp_rdma_pkg::req_entry_t rd_entry
);
  import cdp_rdma_pkg::*;

  req_entry_t mem [REQ_FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0] count;
  logic wr_en;
  logic rd_en;

  assign full = (count == (FIFO_PTR_W + 1)'(REQ_FIFO_DEPTH));
  assign empty = (count == '0);
  // a pop frees the slot in the same cycle
  assign wr_en = push & (~full | pop);
  assign rd_en = pop & ~empty;

  // head is read straight from storage
  assign rd_entry = mem[rd_ptr];

  // storage
  always_ff @(posedge nvdla_core_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_entry;
    end
  end

  // pointers wrap on power of two depth
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // occupancy
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/cdp_rdma_req_issue.sv ====
`timescale 1ns/1ns

module cdp_rdma_req_issue (
  input  logic                                  empty,
  input  cdp_rdma_pkg::req_entry_t              head,
  input  logic                                  dma_rd_req_ready,
  input  logic                                  cq_wr_prdy,
  output logic                                  pop,
  output logic                                  dma_rd_req_valid,
  output logic [cdp_rdma_pkg::DMA_REQ_PD_W-1:0] dma_rd_req_pd,
  output logic                                  cq_wr_pvld,
  output logic [cdp_rdma_pkg::CQ_PD_W-1:0]      cq_wr_pd,
  output logic                                  stall,
  output logic                                  layer_end
);
  import cdp_rdma_pkg::*;

  // ==============================
  // joint accept
  // ==============================
  // each side waits on the other's ready
  assign dma_rd_req_valid = ~empty & cq_wr_prdy;
  assign cq_wr_pvld = ~empty & dma_rd_req_ready;
  // both take the head together
  assign pop = ~empty & dma_rd_req_ready & cq_wr_prdy;

  // ==============================
  // payloads
  // ==============================
  // size zero extended above the address
  assign dma_rd_req_pd = {{(DMA_SIZE_W - $bits(size_t)){1'b0}}, head.size, head.addr};
  // size low, then last w, h, c
  assign cq_wr_pd = {head.last_c, head.last_h, head.last_w, head.size};

  // dma side held off
  assign stall = dma_rd_req_valid & ~dma_rd_req_ready;
  // final entry of the cube accepted
  assign layer_end = pop & head.last_w & head.last_h & head.last_c;

endmodule

// ==== design/cdp_rdma_stall_perf.sv ====
`timescale 1ns/1ns

module cdp_rdma_stall_perf (
  input  logic                            nvdla_core_clk,
  input  logic                            nvdla_core_rstn,
  input  logic                            dma_en,
  input  logic                            stall,
  input  logic                            layer_end,
  output logic [cdp_rdma_pkg::PERF_W-1:0] perf_read_stall_d0,
  output logic [cdp_rdma_pkg::PERF_W-1:0] perf_read_stall_d1
);
  import cdp_rdma_pkg::*;

  logic [PERF_W-1:0] stall_cnt;
  logic [PERF_W-1:0] stall_cnt_nxt;
  logic cnt_inc;
  // low selects d0
  logic layer_flag;

  // count only when the layer reads through dma
  assign cnt_inc = dma_en & stall;
  // include a stall in the layer end cycle
  assign stall_cnt_nxt = stall_cnt + PERF_W'(cnt_inc);

  // ==============================
  // stall counter
  // ==============================
  // restart at every layer end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      stall_cnt <= '0;
    end else if (layer_end) begin
      stall_cnt <= '0;
    end else begin
      stall_cnt <= stall_cnt_nxt;
    end
  end

  // ==============================
  // ping-pong result registers
  // ==============================
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      layer_flag <= 1'b0;
      perf_read_stall_d0 <= '0;
      perf_read_stall_d1 <= '0;
    end else if (layer_end) begin
      layer_flag <= ~layer_flag;
      if (layer_flag) perf_read_stall_d1 <= stall_cnt_nxt;
      else perf_read_stall_d0 <= stall_cnt_nxt;
    end
  end

endmodule

// ==== design/cdp_rdma_ig.sv ====
`timescale 1ns/1ns

module cdp_rdma_ig (
  input  logic                                  nvdla_core_clk,
  input  logic                                  nvdla_core_rstn,
  input  logic                                  op_en,
  input  logic                                  eg_done,
  input  logic                                  dma_en,
  input  cdp_rdma_pkg::cube_dim_t               channel,
  input  cdp_rdma_pkg::cube_dim_t               height,
  input  cdp_rdma_pkg::cube_dim_t               width,
  input  cdp_rdma_pkg::addr_t                   src_base_addr,
  input  cdp_rdma_pkg::stride_t                 src_line_stride,
  input  cdp_rdma_pkg::stride_t                 src_surface_stride,
  input  logic                                  dma_rd_req_ready,
  input  logic                                  cq_wr_prdy,
  output logic                                  dma_rd_req_valid,
  output logic [cdp_rdma_pkg::DMA_REQ_PD_W-1:0] dma_rd_req_pd,
  output logic                                  cq_wr_pvld,
  output logic [cdp_rdma_pkg::CQ_PD_W-1:0]      cq_wr_pd,
  output logic [cdp_rdma_pkg::PERF_W-1:0]       perf_read_stall_d0,
  output logic [cdp_rdma_pkg::PERF_W-1:0]       perf_read_stall_d1
);
  import cdp_rdma_pkg::*;

  // walker to fifo
  logic push;
  logic full;
  req_entry_t wr_entry;
  // fifo to issue
  logic pop;
  logic empty;
  req_entry_t head;
  // issue to perf
  logic stall;
  logic layer_end;

  // ==============================
  // producer
  // ==============================
  cdp_rdma_cube_walker cdp_rdma_cube_walker_inst (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_en              (op_en),
    .eg_done            (eg_done),
    .channel            (channel),
    .height             (height),
    .width              (width),
    .src_base_addr      (src_base_addr),
    .src_line_stride    (src_line_stride),
    .src_surface_stride (src_surface_stride),
    .full               (full),
    .push               (push),
    .entry              (wr_entry)
  );

  // pending requests
  cdp_rdma_req_fifo cdp_rdma_req_fifo_inst (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .push            (push),
    .pop             (pop),
    .wr_entry        (wr_entry),
    .full            (full),
    .empty           (empty),
    .rd_entry        (head)
  );

  // ==============================
  // consumer
  // ==============================
  cdp_rdma_req_issue cdp_rdma_req_issue_inst (
    .empty            (empty),
    .head             (head),
    .dma_rd_req_ready (dma_rd_req_ready),
    .cq_wr_prdy       (cq_wr_prdy),
    .pop              (pop),
    .dma_rd_req_valid (dma_rd_req_valid),
    .dma_rd_req_pd    (dma_rd_req_pd),
    .cq_wr_pvld       (cq_wr_pvld),
    .cq_wr_pd         (cq_wr_pd),
    .stall            (stall),
    .layer_end        (layer_end)
  );

  // read stall perf
  cdp_rdma_stall_perf cdp_rdma_stall_perf_inst (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .dma_en             (dma_en),
    .stall              (stall),
    .layer_end          (layer_end),
    .perf_read_stall_d0 (perf_read_stall_d0),
    .perf_read_stall_d1 (perf_read_stall_d1)
  );

endmodule

// ==== testbench/cdp_rdma_ig_tb.sv ====
`timescale 1ns/1ns

module cdp_rdma_ig_tb;
  import cdp_rdma_pkg::*;

  localparam int CLK_PERIOD = 10;
  // cube configs, each dimension minus one
  localparam cube_dim_t L1_W = 13'd5;
  localparam cube_dim_t L1_H = 13'd1;
  localparam cube_dim_t L1_C = 13'd95;
  localparam cube_dim_t L2_W = 13'd20;
  localparam cube_dim_t L2_H = 13'd1;
  localparam cube_dim_t L2_C = 13'd70;
  localparam cube_dim_t L4_W = 13'd15;
  localparam cube_dim_t L4_H = 13'd2;
  localparam cube_dim_t L4_C = 13'd40;

  logic nvdla_core_clk;
  logic nvdla_core_rstn;
  logic op_en;
  logic eg_done;
  logic dma_en;
  cube_dim_t channel;
  cube_dim_t height;
  cube_dim_t width;
  addr_t src_base_addr;
  stride_t src_line_stride;
  stride_t src_surface_stride;
  logic dma_rd_req_ready;
  logic cq_wr_prdy;
  logic dma_rd_req_valid;
  logic [DMA_REQ_PD_W-1:0] dma_rd_req_pd;
  logic cq_wr_pvld;
  logic [CQ_PD_W-1:0] cq_wr_pd;
  logic [31:0] perf_read_stall_d0;
  logic [31:0] perf_read_stall_d1;

  // reference walk state, position of the next request
  int unsigned m_ch;
  int unsigned m_wg;
  int unsigned m_ln;
  int unsigned m_cnt;
  int unsigned total_acc;
  int unsigned total_reqs;
  int unsigned grp_num;
  int unsigned exp_reqs;
  logic [31:0] m_stall;
  logic [31:0] m_d0;
  logic [31:0] m_d1;
  logic m_sel;
  logic m_wait;
  logic op_seen;
  logic accept;
  // layer end as flagged in the accepted queue entry
  logic dut_end;
  logic exp_lw;
  logic exp_lh;
  logic exp_lc;
  logic exp_end;
  size_t exp_size;
  addr_t exp_addr;
  logic [63:0] addr_sum;
  logic [DMA_REQ_PD_W-1:0] exp_dma_pd;
  logic [CQ_PD_W-1:0] exp_cq_pd;
  // last cycle's payloads for the hold checks
  logic [DMA_REQ_PD_W-1:0] prev_dma_pd;
  logic [CQ_PD_W-1:0] prev_cq_pd;
  logic held_dma;
  logic held_cq;

  cdp_rdma_ig cdp_rdma_ig_inst (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_en              (op_en),
    .eg_done            (eg_done),
    .dma_en             (dma_en),
    .channel            (channel),
    .height             (height),
    .width              (width),
    .src_base_addr      (src_base_addr),
    .src_line_stride    (src_line_stride),
    .src_surface_stride (src_surface_stride),
    .dma_rd_req_ready   (dma_rd_req_ready),
    .cq_wr_prdy         (cq_wr_prdy),
    .dma_rd_req_valid   (dma_rd_req_valid),
    .dma_rd_req_pd      (dma_rd_req_pd),
    .cq_wr_pvld         (cq_wr_pvld),
    .cq_wr_pd           (cq_wr_pd),
    .perf_read_stall_d0 (perf_read_stall_d0),
    .perf_read_stall_d1 (perf_read_stall_d1)
  );

  initial nvdla_core_clk = 1'b0;
  always #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  // width groups x channel groups x lines
  function automatic int unsigned layer_reqs(input cube_dim_t w, input cube_dim_t h,
                                             input cube_dim_t c);
    return ((int'(w) + 8) / 8) * ((int'(c) >> ATOM_SHIFT) + 1) * (int'(h) + 1);
  endfunction

  // ==============================
  // reference model
  // ==============================
  assign accept = dma_rd_req_valid & dma_rd_req_ready;
  assign dut_end = accept & (&cq_wr_pd[CQ_PD_W-1:CQ_PD_W-3]);

  always_comb begin
    grp_num = (int'(width) + 8) / 8;
    exp_reqs = layer_reqs(width, height, channel);
    exp_lw = (m_wg == grp_num - 1);
    exp_lh = (m_ln == int'(height));
    exp_lc = (m_ch == (int'(channel) >> ATOM_SHIFT));
    exp_end = exp_lw & exp_lh & exp_lc;
    // full groups except a last partial one
    if (m_wg == 0 && grp_num > 1) exp_size = 3'd7;
    else if (exp_lw) exp_size = size_t'(width % 8);
    else exp_size = 3'd7;
    // one width group is 8 atoms of 32 bytes
    addr_sum = 64'(src_base_addr) + 64'(m_ln) * 64'(src_line_stride) + 64'(m_wg) * 256 +
               64'(m_ch) * 64'(src_surface_stride);
    exp_addr = addr_t'(addr_sum);
    exp_dma_pd = DMA_REQ_PD_W'({exp_size, exp_addr});
    exp_cq_pd = {exp_lc, exp_lh, exp_lw, exp_size};
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      m_ch <= 0;
      m_wg <= 0;
      m_ln <= 0;
      m_cnt <= 0;
      total_acc <= 0;
      m_stall <= '0;
      m_d0 <= '0;
      m_d1 <= '0;
      m_sel <= 1'b0;
      m_wait <= 1'b0;
      op_seen <= 1'b0;
      prev_dma_pd <= '0;
      prev_cq_pd <= '0;
      held_dma <= 1'b0;
      held_cq <= 1'b0;
    end else begin
      if (op_en) op_seen <= 1'b1;
      if (eg_done) m_wait <= 1'b0;
      prev_dma_pd <= dma_rd_req_pd;
      prev_cq_pd <= cq_wr_pd;
      held_dma <= dma_rd_req_valid & ~dma_rd_req_ready;
      held_cq <= cq_wr_pvld & ~cq_wr_prdy;
      // channel innermost, then width group, then line
      if (accept) begin
        total_acc <= total_acc + 1;
        m_ch <= exp_lc ? 0 : m_ch + 1;
        if (exp_lc) m_wg <= exp_lw ? 0 : m_wg + 1;
        if (exp_lc && exp_lw) m_ln <= exp_lh ? 0 : m_ln + 1;
        m_cnt <= dut_end ? 0 : m_cnt + 1;
      end
      // accept implies ready, so no stall in the layer end cycle
      if (accept && exp_end) begin
        m_wait <= 1'b1;
        m_sel <= ~m_sel;
        m_stall <= '0;
        if (m_sel) m_d1 <= m_stall;
        else m_d0 <= m_stall;
      end else if (dma_en && dma_rd_req_valid && !dma_rd_req_ready) begin
        m_stall <= m_stall + 1;
      end
    end
  end

  // ==============================
  // checks
  // ==============================
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !op_seen |-> (!dma_rd_req_valid && !cq_wr_pvld &&
                  perf_read_stall_d0 == 0 && perf_read_stall_d1 == 0))
    else stop_with_failure("outputs active after reset before op_en");

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    accept |-> dma_rd_req_pd == exp_dma_pd)
    else stop_with_failure($sformatf("CHECK FAILED dma_rd_req_pd got %h expected %h",
                                     $sampled(dma_rd_req_pd), $sampled(exp_dma_pd)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    dut_end |-> (m_cnt + 1 == exp_reqs))
    else stop_with_failure($sformatf("CHECK FAILED layer request count got %h expected %h",
                                     $sampled(m_cnt) + 1, $sampled(exp_reqs)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    accept == (cq_wr_pvld && cq_wr_prdy))
    else stop_with_failure("DMA port and context queue accepted in different cycles");

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    accept |-> cq_wr_pd == exp_cq_pd)
    else stop_with_failure($sformatf("CHECK FAILED cq_wr_pd got %h expected %h",
                                     $sampled(cq_wr_pd), $sampled(exp_cq_pd)));

  // payload held while waiting
  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    held_dma |-> dma_rd_req_pd == prev_dma_pd)
    else stop_with_failure($sformatf("CHECK FAILED dma_rd_req_pd got %h expected %h",
                                     $sampled(dma_rd_req_pd), $sampled(prev_dma_pd)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    held_cq |-> cq_wr_pd == prev_cq_pd)
    else stop_with_failure($sformatf("CHECK FAILED cq_wr_pd got %h expected %h",
                                     $sampled(cq_wr_pd), $sampled(prev_cq_pd)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    perf_read_stall_d0 == m_d0)
    else stop_with_failure($sformatf("CHECK FAILED perf_read_stall_d0 got %h expected %h",
                                     $sampled(perf_read_stall_d0), $sampled(m_d0)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    perf_read_stall_d1 == m_d1)
    else stop_with_failure($sformatf("CHECK FAILED perf_read_stall_d1 got %h expected %h",
                                     $sampled(perf_read_stall_d1), $sampled(m_d1)));

  assert property (@(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    m_wait |-> (!dma_rd_req_valid && !cq_wr_pvld))
    else stop_with_failure("request offered after layer end before eg_done");

  // ==============================
  // stimulus
  // ==============================
  // about 70 percent ready on each side
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      dma_rd_req_ready <= ($urandom % 10) < 7;
      cq_wr_prdy <= ($urandom % 10) < 7;
    end
  end

  task automatic run_layer(input cube_dim_t w, input cube_dim_t h, input cube_dim_t c,
                           input addr_t base, input stride_t ls, input stride_t ss,
                           input logic en, input logic back_to_back);
    @(negedge nvdla_core_clk);
    width = w;
    height = h;
    channel = c;
    src_base_addr = base;
    src_line_stride = ls;
    src_surface_stride = ss;
    dma_en = en;
    op_en = 1'b1;
    wait (m_wait);
    // op_en kept high, second pass starts on its own
    if (back_to_back) begin
      @(negedge nvdla_core_clk);
      eg_done = 1'b1;
      @(negedge nvdla_core_clk);
      eg_done = 1'b0;
      wait (m_wait);
    end
    @(negedge nvdla_core_clk);
    op_en = 1'b0;
    @(negedge nvdla_core_clk);
    eg_done = 1'b1;
    @(negedge nvdla_core_clk);
    eg_done = 1'b0;
    repeat (3) @(negedge nvdla_core_clk);
  endtask

  initial begin
    void'($urandom(32'h664a_0e25));
    nvdla_core_rstn = 1'b0;
    op_en = 1'b0;
    eg_done = 1'b0;
    dma_en = 1'b0;
    channel = '0;
    height = '0;
    width = '0;
    src_base_addr = '0;
    src_line_stride = '0;
    src_surface_stride = '0;
    dma_rd_req_ready = 1'b0;
    cq_wr_prdy = 1'b0;
    repeat (2) @(posedge nvdla_core_clk);
    @(negedge nvdla_core_clk);
    nvdla_core_rstn = 1'b1;
    repeat (4) @(negedge nvdla_core_clk);
    run_layer(L1_W, L1_H, L1_C, 40'h00_0010_0000, 32'h0000_0400, 32'h0000_2000, 1'b1, 1'b0);
    run_layer(L2_W, L2_H, L2_C, 40'h12_3456_7800, 32'h0000_1a40, 32'h0004_0300, 1'b1, 1'b0);
    // no stall counting without dma_en
    run_layer(L2_W, L2_H, L2_C, 40'h12_3456_7800, 32'h0000_1a40, 32'h0004_0300, 1'b0, 1'b0);
    run_layer(L4_W, L4_H, L4_C, 40'hff_ffff_f000, 32'h0000_0a00, 32'h0001_1100, 1'b1, 1'b1);
    repeat (5) @(negedge nvdla_core_clk);
    if (total_acc != total_reqs) begin
      stop_with_failure($sformatf("run accepted %0d requests, expected %0d",
                                  total_acc, total_reqs));
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

  // ==============================
  // watchdog
  // ==============================
  // last layer runs twice back to back
  initial begin
    total_reqs = layer_reqs(L1_W, L1_H, L1_C) + 2 * layer_reqs(L2_W, L2_H, L2_C) +
                 2 * layer_reqs(L4_W, L4_H, L4_C);
    #(total_reqs * 40 * CLK_PERIOD);
    stop_with_failure("timeout, layers did not finish in time");
  end

endmodule

// ==== filelist.f ====
design/cdp_rdma_pkg.sv
design/cdp_rdma_cube_walker.sv
design/cdp_rdma_req_fifo.sv
design/cdp_rdma_req_issue.sv
design/cdp_rdma_stall_perf.sv
design/cdp_rdma_ig.sv
testbench/cdp_rdma_ig_tb.sv

// ==== Bender.yml ====
package:
  name: cdp_rdma_ig

sources:
  - design/cdp_rdma_pkg.sv
  - design/cdp_rdma_cube_walker.sv
  - design/cdp_rdma_req_fifo.sv
  - design/cdp_rdma_req_issue.sv
  - design/cdp_rdma_stall_perf.sv
  - design/cdp_rdma_ig.sv
  - target: test
    files:
      - testbench/cdp_rdma_ig_tb.sv
